// File: ats_query_consts.svh
// ATS query probe constants: widths, register map, IDs and reset values
`ifndef ATS_QUERY_CONSTS_SVH
`define ATS_QUERY_CONSTS_SVH

// Datapath widths
`define ATS_COUNTER_BITS 40
`define ATS_PASID_BITS   20
`define ATS_LEN_BITS     10
`define ATS_TAG_BITS     8

// Reset and clear values
`define ATS_LEN_RESET    10'd2
`define ATS_CPL_POISON   64'h0000_0000_dead_beef

// Accelerator identification and system information
`define ATS_AFU_ID_L     64'h9f4c_2b71_e05a_83d6
`define ATS_AFU_ID_H     64'h51c8_0e3d_a7b2_46f9
`define ATS_CLK_MHZ      16'd250
`define ATS_BUS_BYTES    16'd64

// Read register indices, taken from address bits 4:1
`define ATS_REG_DFH      4'd0
`define ATS_REG_ID_L     4'd1
`define ATS_REG_ID_H     4'd2
`define ATS_REG_SYSINFO  4'd7
`define ATS_REG_RD_SENT  4'd8
`define ATS_REG_CPL_RCVD 4'd9
`define ATS_REG_LAST_CPL 4'd10
`define ATS_REG_CYCLES   4'd12

// Write register indices, taken from address bits 3:1
`define ATS_WREG_PASID   3'd0
`define ATS_WREG_BASE    3'd1
`define ATS_WREG_LEN     3'd2
`define ATS_WREG_CMD     3'd7

`endif

// File: ats_query_ifs.sv
// Internal buses carrying read configuration and statistics between blocks
`include "ats_query_consts.svh"

// Configuration written over MMIO, plus the command pulses
interface rd_cfg_if;
    logic [`ATS_PASID_BITS-1:0] pasid;
    logic [63:0]                base_addr;
    logic [`ATS_LEN_BITS-1:0]   length;
    logic                       ats_en;
    logic                       start;
    logic                       stats_clr;

    modport source (
        output pasid, base_addr, length, ats_en, start, stats_clr
    );

    modport sink (
        input pasid, base_addr, length, ats_en, start, stats_clr
    );
endinterface

// Statistics gathered by the request and completion paths
interface stats_if import ats_query_pkg::*; ();
    counter_t    rd_sent;
    counter_t    cycles;
    counter_t    cpl_rcvd;
    logic [63:0] last_cpl;

    modport rd_source (
        output rd_sent, cycles
    );

    modport cpl_source (
        output cpl_rcvd, last_cpl
    );

    modport reader (
        input rd_sent, cycles, cpl_rcvd, last_cpl
    );
endinterface

// File: ats_query_pkg.sv
// Shared types for the ATS query probe: counters, command word, read request
`include "ats_query_consts.svh"

package ats_query_pkg;

    // One statistics counter
    typedef logic [`ATS_COUNTER_BITS-1:0] counter_t;

    // Command register layout, bit 0 is ATS, bit 1 is plain read
    typedef struct packed {
        logic [60:0] rsvd;
        logic        page;
        logic        rd_en;
        logic        ats_en;
    } cmd_t;

    // MMIO write data, raw for config registers or decoded as a command
    typedef union packed {
        logic [63:0] raw;
        cmd_t        cmd;
    } cmd_word_u;

    // Host read request fields
    typedef struct packed {
        logic [63:0]                addr;
        logic                       addr64;
        logic [`ATS_LEN_BITS-1:0]   length;
        logic [`ATS_TAG_BITS-1:0]   tag;
        logic                       ats;
        logic [`ATS_PASID_BITS-1:0] pasid;
    } rd_req_t;

endpackage

// File: ats_query_top.sv
// ATS query probe top level connecting MMIO, read request and completion paths
`include "ats_query_consts.svh"

module ats_query_top import ats_query_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,

    // MMIO writes, always accepted
    input  logic                       mmio_wr_valid,
    input  logic [4:0]                 mmio_wr_addr,
    input  logic [63:0]                mmio_wr_data,

    // MMIO read requests and completions
    input  logic                       mmio_rd_valid,
    output logic                       mmio_rd_ready,
    input  logic [4:0]                 mmio_rd_addr,
    input  logic [7:0]                 mmio_rd_tag,
    output logic                       cpl_out_valid,
    input  logic                       cpl_out_ready,
    output logic [7:0]                 cpl_out_tag,
    output logic [63:0]                cpl_out_data,

    // Host read requests
    output logic                       rd_req_valid,
    input  logic                       rd_req_ready,
    output logic [63:0]                rd_req_addr,
    output logic                       rd_req_addr64,
    output logic [`ATS_LEN_BITS-1:0]   rd_req_length,
    output logic [`ATS_TAG_BITS-1:0]   rd_req_tag,
    output logic                       rd_req_ats,
    output logic [`ATS_PASID_BITS-1:0] rd_req_pasid,

    // Host completions
    input  logic                       cpl_valid,
    input  logic                       cpl_last,
    input  logic                       cpl_final,
    input  logic [63:0]                cpl_data
);

    rd_cfg_if cfg_bus ();
    stats_if  stats_bus ();
    rd_req_t  req;

    mmio_wr_decode i_wr_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (mmio_wr_valid),
        .wr_addr  (mmio_wr_addr),
        .wr_data  (mmio_wr_data),
        .cfg      (cfg_bus.source)
    );

    rd_req_gen i_rd_req_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg_bus.sink),
        .stats     (stats_bus.rd_source),
        .cpl_beat  (cpl_valid),
        .req_valid (rd_req_valid),
        .req_ready (rd_req_ready),
        .req       (req)
    );

    cpl_monitor i_cpl_monitor (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpl_valid (cpl_valid),
        .cpl_last  (cpl_last),
        .cpl_final (cpl_final),
        .cpl_data  (cpl_data),
        .cfg       (cfg_bus.sink),
        .stats     (stats_bus.cpl_source)
    );

    mmio_rd_resp i_rd_resp (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_valid  (mmio_rd_valid),
        .rd_ready  (mmio_rd_ready),
        .rd_addr   (mmio_rd_addr),
        .rd_tag    (mmio_rd_tag),
        .stats     (stats_bus.reader),
        .out_valid (cpl_out_valid),
        .out_ready (cpl_out_ready),
        .out_tag   (cpl_out_tag),
        .out_data  (cpl_out_data)
    );

    // Request fields out to plain ports
    assign rd_req_addr   = req.addr;
    assign rd_req_addr64 = req.addr64;
    assign rd_req_length = req.length;
    assign rd_req_tag    = req.tag;
    assign rd_req_ats    = req.ats;
    assign rd_req_pasid  = req.pasid;

endmodule

// File: compile.f
+incdir+.
ats_query_pkg.sv
ats_query_ifs.sv
mmio_wr_decode.sv
rd_req_gen.sv
cpl_monitor.sv
mmio_rd_resp.sv
ats_query_top.sv
tb_ats_query.sv

// File: cpl_monitor.sv
// Host completion monitor counting final packets and capturing first-beat data
`include "ats_query_consts.svh"

module cpl_monitor (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cpl_valid,
    input  logic        cpl_last,
    input  logic        cpl_final,
    input  logic [63:0] cpl_data,
    rd_cfg_if.sink      cfg,
    stats_if.cpl_source stats
);

    logic sop;
    logic final_reg;
    logic is_final;

    // Final flag comes from the first beat and is held for the rest
    assign is_final = sop ? cpl_final : final_reg;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sop       <= 1'b1;
            final_reg <= 1'b0;
        end
        else if (cpl_valid)
        begin
            sop <= cpl_last;
            if (sop)
                final_reg <= cpl_final;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n || cfg.stats_clr)
            stats.cpl_rcvd <= '0;
        else if (cpl_valid && cpl_last && is_final)
            stats.cpl_rcvd <= stats.cpl_rcvd + 1'b1;
    end

    // Low 64 bits of the first beat, enough for a translation response
    always_ff @(posedge clk)
    begin
        if (!rst_n || cfg.stats_clr)
            stats.last_cpl <= `ATS_CPL_POISON;
        else if (cpl_valid && sop)
            stats.last_cpl <= cpl_data;
    end

endmodule

// File: mmio_rd_resp.sv
// MMIO read responder with a two-entry request FIFO and register read mux
`include "ats_query_consts.svh"

module mmio_rd_resp (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rd_valid,
    output logic        rd_ready,
    input  logic [4:0]  rd_addr,
    input  logic [7:0]  rd_tag,
    stats_if.reader     stats,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [7:0]  out_tag,
    output logic [63:0] out_data
);

    logic [4:0]  fifo_addr [2];
    logic [7:0]  fifo_tag  [2];
    logic        wr_ptr;
    logic        rd_ptr;
    logic [1:0]  fifo_count;
    logic [1:0]  count_next;
    logic        push;
    logic        pop;
    logic [4:0]  head_addr;
    logic [63:0] reg_data;

    // ====================================================================
    // Request FIFO
    // ====================================================================

    assign push       = rd_valid && rd_ready;
    assign pop        = out_valid && out_ready;
    assign out_valid  = (fifo_count != 2'd0);
    assign count_next = fifo_count + 2'(push) - 2'(pop);

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            fifo_addr[wr_ptr] <= rd_addr;
            fifo_tag[wr_ptr]  <= rd_tag;
        end
    end

    // Ready is registered from the next occupancy
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            fifo_count <= 2'd0;
            rd_ready   <= 1'b1;
        end
        else
        begin
            wr_ptr     <= wr_ptr ^ push;
            rd_ptr     <= rd_ptr ^ pop;
            fifo_count <= count_next;
            rd_ready   <= (count_next != 2'd2);
        end
    end

    // ====================================================================
    // Register read mux, uses live counter values
    // ====================================================================

    assign head_addr = fifo_addr[rd_ptr];
    assign out_tag   = fifo_tag[rd_ptr];

    always_comb
    begin
        case (head_addr[4:1])
            `ATS_REG_DFH:
            begin
                reg_data = '0;
                // AFU feature type, end of list
                reg_data[63:60] = 4'h1;
                reg_data[40]    = 1'b1;
            end
            `ATS_REG_ID_L:     reg_data = `ATS_AFU_ID_L;
            `ATS_REG_ID_H:     reg_data = `ATS_AFU_ID_H;
            `ATS_REG_SYSINFO:  reg_data = {32'h0, `ATS_CLK_MHZ, `ATS_BUS_BYTES};
            `ATS_REG_RD_SENT:  reg_data = 64'(stats.rd_sent);
            `ATS_REG_CPL_RCVD: reg_data = 64'(stats.cpl_rcvd);
            `ATS_REG_LAST_CPL: reg_data = stats.last_cpl;
            `ATS_REG_CYCLES:   reg_data = 64'(stats.cycles);
            default:           reg_data = '0;
        endcase

        // Odd address asks for the upper dword
        if (head_addr[0])
            reg_data[31:0] = reg_data[63:32];
    end

    assign out_data = reg_data;

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> fifo_count != 2'd2)
        else $error("MMIO read pushed into a full FIFO");

endmodule

// File: mmio_wr_decode.sv
// MMIO write decoder producing read configuration and command pulses
`include "ats_query_consts.svh"

module mmio_wr_decode import ats_query_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_valid,
    input  logic [4:0] wr_addr,
    input  cmd_word_u  wr_data,
    rd_cfg_if.source   cfg
);

    logic [2:0] wr_idx;
    logic       cmd_hit;

    assign wr_idx  = wr_addr[3:1];
    assign cmd_hit = wr_valid && (wr_idx == `ATS_WREG_CMD);

    // Address and PASID registers
    always_ff @(posedge clk)
    begin
        if (wr_valid && (wr_idx == `ATS_WREG_PASID))
        begin
            cfg.pasid <= wr_data.raw[`ATS_PASID_BITS-1:0];
        end
        if (wr_valid && (wr_idx == `ATS_WREG_BASE))
        begin
            cfg.base_addr <= wr_data.raw;
        end
    end

    // Length, mode and one-cycle command pulses
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cfg.length    <= `ATS_LEN_RESET;
            cfg.ats_en    <= 1'b0;
            cfg.start     <= 1'b0;
            cfg.stats_clr <= 1'b0;
        end
        else
        begin
            if (wr_valid && (wr_idx == `ATS_WREG_LEN))
            begin
                cfg.length <= wr_data.raw[`ATS_LEN_BITS-1:0];
            end
            if (cmd_hit)
            begin
                cfg.ats_en <= wr_data.cmd.ats_en;
            end
            // Page bit is ignored here
            cfg.start     <= cmd_hit && (wr_data.cmd.rd_en || wr_data.cmd.ats_en);
            cfg.stats_clr <= cmd_hit;
        end
    end

    // Software spaces command writes, so start stays a single-cycle pulse
    a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        cfg.start |=> !cfg.start)
        else $error("start held high for two cycles");

endmodule

// File: rd_req_gen.sv
// Host read request generator with rolling tag, active tracking and counters
`include "ats_query_consts.svh"

module rd_req_gen import ats_query_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    rd_cfg_if.sink      cfg,
    stats_if.rd_source  stats,
    input  logic        cpl_beat,
    output logic        req_valid,
    input  logic        req_ready,
    output rd_req_t     req
);

    logic                     pending;
    logic                     active;
    logic                     launch;
    logic                     accept;
    logic [`ATS_TAG_BITS-1:0] tag;

    // Launch once any previous query has seen its completion
    assign launch = pending && !active && !req_valid;
    assign accept = req_valid && req_ready;

    // ====================================================================
    // Request control
    // ====================================================================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pending   <= 1'b0;
            req_valid <= 1'b0;
            active    <= 1'b0;
            tag       <= '0;
        end
        else
        begin
            if (cfg.start)
                pending <= 1'b1;
            else if (launch)
                pending <= 1'b0;

            if (launch)
                req_valid <= 1'b1;
            else if (accept)
                req_valid <= 1'b0;

            // Any completion beat ends the query
            if (accept)
                active <= 1'b1;
            else if (cpl_beat)
                active <= 1'b0;

            if (accept)
                tag <= tag + 1'b1;
        end
    end

    // Fields are frozen at launch so later MMIO writes cannot disturb them
    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            req.addr   <= {cfg.base_addr[63:12], 12'h000};
            req.addr64 <= |cfg.base_addr[63:32];
            req.length <= cfg.length;
            req.tag    <= tag;
            req.ats    <= cfg.ats_en;
            req.pasid  <= cfg.ats_en ? cfg.pasid : '0;
        end
    end

    // ====================================================================
    // Statistics
    // ====================================================================

    always_ff @(posedge clk)
    begin
        if (!rst_n || cfg.stats_clr)
        begin
            stats.rd_sent <= '0;
            stats.cycles  <= '0;
        end
        else
        begin
            if (accept)
                stats.rd_sent <= stats.rd_sent + 1'b1;
            if (active)
                stats.cycles <= stats.cycles + 1'b1;
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("read request changed under back-pressure");

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the ATS query probe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_ats_query -f compile.f -o sim_ats_query

./obj_dir/sim_ats_query | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

// File: tb_ats_query.sv
// Testbench for the ATS query probe, pin-level model with handshake assertions
`include "ats_query_consts.svh"

module tb_ats_query import ats_query_pkg::*;;
    timeunit 1ns;
    timeprecision 1ns;

    // Whole run takes roughly 400 cycles, the limit is about ten times that
    localparam int CYCLE_LIMIT = 4000;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       mmio_wr_valid;
    logic [4:0]                 mmio_wr_addr;
    logic [63:0]                mmio_wr_data;
    logic                       mmio_rd_valid;
    logic                       mmio_rd_ready;
    logic [4:0]                 mmio_rd_addr;
    logic [7:0]                 mmio_rd_tag;
    logic                       cpl_out_valid;
    logic                       cpl_out_ready;
    logic [7:0]                 cpl_out_tag;
    logic [63:0]                cpl_out_data;
    logic                       rd_req_valid;
    logic                       rd_req_ready;
    logic [63:0]                rd_req_addr;
    logic                       rd_req_addr64;
    logic [`ATS_LEN_BITS-1:0]   rd_req_length;
    logic [`ATS_TAG_BITS-1:0]   rd_req_tag;
    logic                       rd_req_ats;
    logic [`ATS_PASID_BITS-1:0] rd_req_pasid;
    logic                       cpl_valid;
    logic                       cpl_last;
    logic                       cpl_final;
    logic [63:0]                cpl_data;

    // Model state, updated from the DUT pins at each rising edge
    logic [`ATS_PASID_BITS-1:0] m_pasid;
    logic [63:0]                m_base;
    logic [`ATS_LEN_BITS-1:0]   m_len;
    logic                       m_ats;
    logic [`ATS_TAG_BITS-1:0]   m_tag;
    counter_t                   m_sent;
    counter_t                   m_rcvd;
    counter_t                   m_cycles;
    logic [63:0]                m_last;
    logic                       m_active;
    logic                       m_sop;
    logic                       m_final;
    int                         starts_seen;
    int                         req_seen;
    int                         rd_pushes;
    int                         rd_pops;
    logic [4:0]                 exp_addr_mem [16];
    logic [7:0]                 exp_tag_mem [16];
    logic [4:0]                 exp_head_addr;
    logic [63:0]                exp_head_data;
    logic [63:0]                cycles_rsp;

    int          req_errs = 0;
    int          hold_errs = 0;
    int          rsp_errs = 0;
    int          seq_errs = 0;
    int          starts_sent;
    int          cycle_count;
    logic [7:0]  next_mmio_tag;

    always #50 clk = ~clk;

    ats_query_top i_dut (.*);

    // ======================================================================
    // Reference model
    // ======================================================================

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            m_pasid     <= '0;
            m_base      <= '0;
            m_len       <= `ATS_LEN_RESET;
            m_ats       <= 1'b0;
            m_tag       <= '0;
            m_sent      <= '0;
            m_rcvd      <= '0;
            m_cycles    <= '0;
            m_last      <= `ATS_CPL_POISON;
            m_active    <= 1'b0;
            m_sop       <= 1'b1;
            m_final     <= 1'b0;
            starts_seen <= 0;
            req_seen    <= 0;
            rd_pushes   <= 0;
            rd_pops     <= 0;
            cycles_rsp  <= '0;
        end
        else
        begin
            // A packet counts on its last beat when its first beat said final
            if (cpl_valid)
            begin
                if (m_sop)
                begin
                    m_final <= cpl_final;
                    m_last  <= cpl_data;
                end
                if (cpl_last && (m_sop ? cpl_final : m_final))
                    m_rcvd <= m_rcvd + 1'b1;
                m_sop <= cpl_last;
            end
            if (m_active)
                m_cycles <= m_cycles + 1'b1;
            if (rd_req_valid && rd_req_ready)
            begin
                m_active <= 1'b1;
                m_tag    <= m_tag + 1'b1;
                m_sent   <= m_sent + 1'b1;
                req_seen <= req_seen + 1;
            end
            else if (cpl_valid)
                m_active <= 1'b0;
            if (mmio_wr_valid)
            begin
                case (mmio_wr_addr[3:1])
                    `ATS_WREG_PASID: m_pasid <= mmio_wr_data[`ATS_PASID_BITS-1:0];
                    `ATS_WREG_BASE:  m_base <= mmio_wr_data;
                    `ATS_WREG_LEN:   m_len <= mmio_wr_data[`ATS_LEN_BITS-1:0];
                    `ATS_WREG_CMD:
                    begin
                        m_ats    <= mmio_wr_data[0];
                        m_sent   <= '0;
                        m_rcvd   <= '0;
                        m_cycles <= '0;
                        m_last   <= `ATS_CPL_POISON;
                        if (mmio_wr_data[1] || mmio_wr_data[0])
                            starts_seen <= starts_seen + 1;
                    end
                    default: ;
                endcase
            end
            if (mmio_rd_valid && mmio_rd_ready)
            begin
                exp_addr_mem[rd_pushes[3:0]] <= mmio_rd_addr;
                exp_tag_mem[rd_pushes[3:0]]  <= mmio_rd_tag;
                rd_pushes <= rd_pushes + 1;
            end
            if (cpl_out_valid && cpl_out_ready)
            begin
                rd_pops <= rd_pops + 1;
                // Low dword read of the cycle counter as returned by the DUT
                if (exp_head_addr == {`ATS_REG_CYCLES, 1'b0})
                    cycles_rsp <= cpl_out_data;
            end
        end
    end

    assign exp_head_addr = exp_addr_mem[rd_pops[3:0]];

    // Register map as software sees it
    always_comb
    begin
        case (exp_head_addr[4:1])
            `ATS_REG_DFH:      exp_head_data = {4'h1, 19'h0, 1'b1, 40'h0};
            `ATS_REG_ID_L:     exp_head_data = `ATS_AFU_ID_L;
            `ATS_REG_ID_H:     exp_head_data = `ATS_AFU_ID_H;
            `ATS_REG_SYSINFO:  exp_head_data = {32'h0, `ATS_CLK_MHZ, `ATS_BUS_BYTES};
            `ATS_REG_RD_SENT:  exp_head_data = {24'h0, m_sent};
            `ATS_REG_CPL_RCVD: exp_head_data = {24'h0, m_rcvd};
            `ATS_REG_LAST_CPL: exp_head_data = m_last;
            `ATS_REG_CYCLES:   exp_head_data = {24'h0, m_cycles};
            default:           exp_head_data = '0;
        endcase
        if (exp_head_addr[0])
            exp_head_data[31:0] = exp_head_data[63:32];
    end

    // ======================================================================
    // Handshake checks
    // ======================================================================

    a_req: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_valid && rd_req_ready |->
            req_seen < starts_seen && rd_req_tag == m_tag
            && rd_req_addr == {m_base[63:12], 12'h000}
            && rd_req_addr64 == (m_base[63:32] != 32'h0)
            && rd_req_length == m_len && rd_req_ats == m_ats
            && rd_req_pasid == (m_ats ? m_pasid : '0))
        else
        begin
            req_errs++;
            $display("FAILED at %0t: req tag %0h addr %0h ats %0b pasid %0h, expected tag %0h",
                     $time, rd_req_tag, rd_req_addr, rd_req_ats, rd_req_pasid, m_tag);
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_valid && !rd_req_ready |=> rd_req_valid
            && $stable({rd_req_addr, rd_req_addr64, rd_req_length,
                        rd_req_tag, rd_req_ats, rd_req_pasid}))
        else
        begin
            hold_errs++;
            $display("FAILED at %0t: read request changed while ready was low", $time);
        end

    a_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        cpl_out_valid && cpl_out_ready |->
            rd_pops != rd_pushes && cpl_out_tag == exp_tag_mem[rd_pops[3:0]]
            && cpl_out_data == exp_head_data)
        else
        begin
            rsp_errs++;
            $display("FAILED at %0t: MMIO read tag %0h data %h, expected tag %0h data %h",
                     $time, cpl_out_tag, cpl_out_data, exp_tag_mem[rd_pops[3:0]], exp_head_data);
        end

    // ======================================================================
    // Stimulus tasks, each starts and ends on a falling edge
    // ======================================================================

    task automatic mmio_write(input logic [4:0] addr, input logic [63:0] data);
        mmio_wr_valid = 1'b1;
        mmio_wr_addr  = addr;
        mmio_wr_data  = data;
        @(negedge clk);
        mmio_wr_valid = 1'b0;
    endtask

    task automatic issue_cmd(input logic [63:0] cmd);
        mmio_write(5'h0e, cmd);
        if (cmd[1] || cmd[0])
            starts_sent++;
    endtask

    task automatic mmio_read(input logic [4:0] addr);
        mmio_rd_valid = 1'b1;
        mmio_rd_addr  = addr;
        mmio_rd_tag   = next_mmio_tag;
        while (!mmio_rd_ready)
            @(negedge clk);
        @(negedge clk);
        mmio_rd_valid = 1'b0;
        next_mmio_tag++;
    endtask

    task automatic wait_reads_done();
        while (rd_pops != rd_pushes)
            @(negedge clk);
    endtask

    task automatic wait_request();
        while (req_seen < starts_sent)
            @(negedge clk);
    endtask

    task automatic send_packet(input int beats, input logic fin, input logic [63:0] first_data);
        for (int i = 0; i < beats; i++)
        begin
            cpl_valid = 1'b1;
            cpl_last  = (i == beats - 1);
            // Only the first beat's final bit matters
            cpl_final = (i == 0) ? fin : 1'($urandom % 2);
            cpl_data  = first_data + 64'(i);
            @(negedge clk);
        end
        cpl_valid = 1'b0;
        cpl_last  = 1'b0;
    endtask

    // Ready inputs toggle randomly for back-pressure
    initial
    begin
        rd_req_ready  = 1'b0;
        cpl_out_ready = 1'b0;
        forever
        begin
            @(negedge clk);
            rd_req_ready  = ($urandom % 2) != 0;
            cpl_out_ready = ($urandom % 2) == 1;
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h334922ea));
        rst_n         = 1'b0;
        mmio_wr_valid = 1'b0;
        mmio_wr_addr  = '0;
        mmio_wr_data  = '0;
        mmio_rd_valid = 1'b0;
        mmio_rd_addr  = '0;
        mmio_rd_tag   = '0;
        cpl_valid     = 1'b0;
        cpl_last      = 1'b0;
        cpl_final     = 1'b0;
        cpl_data      = '0;
        next_mmio_tag = 8'h40;
        starts_sent   = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // ID registers, both dword halves
        for (int a = 0; a < 6; a++)
            mmio_read(5'(a));
        mmio_read(5'd14);
        mmio_read(5'd15);
        mmio_read(5'd31);
        wait_reads_done();

        // Plain read, then an ATS query above 4 GB
        mmio_write(5'h00, 64'h0000_0000_000a_5c3e);
        mmio_write(5'h02, 64'h0000_0000_1234_5abc);
        mmio_write(5'h04, 64'd16);
        issue_cmd(64'h2);
        wait_request();
        send_packet(1, 1'b1, 64'h1111_2222_3333_4444);
        mmio_write(5'h02, 64'h0000_0042_8765_4fff);
        issue_cmd(64'h1);
        wait_request();
        send_packet(2, 1'b1, {$urandom, $urandom});

        // Tag rolls across commands of mixed type
        for (int n = 0; n < 6; n++)
        begin
            mmio_write(5'h04, 64'($urandom_range(1, 1023)));
            issue_cmd({61'h0, 1'($urandom % 2), 2'($urandom_range(1, 3))});
            wait_request();
            send_packet($urandom_range(1, 3), 1'($urandom % 2), {$urandom, $urandom});
        end

        // Mixed final and non-final packets after one query
        issue_cmd(64'h2);
        wait_request();
        send_packet(2, 1'b1, {$urandom, $urandom});
        send_packet(1, 1'b0, {$urandom, $urandom});
        send_packet(3, 1'b1, {$urandom, $urandom});
        send_packet(2, 1'b0, {$urandom, $urandom});
        mmio_read(5'd16);
        mmio_read(5'd18);
        mmio_read(5'd20);
        mmio_read(5'd21);
        mmio_read(5'd24);
        wait_reads_done();
        if (cycles_rsp == 0)
        begin
            seq_errs++;
            $display("FAILED at %0t: cycle counter read back zero after a query", $time);
        end

        // Command with no enable bits only clears the statistics
        issue_cmd(64'h0);
        mmio_read(5'd16);
        mmio_read(5'd18);
        mmio_read(5'd20);
        mmio_read(5'd21);
        mmio_read(5'd24);
        wait_reads_done();

        // Back-to-back reads fill the request FIFO
        for (int n = 0; n < 16; n++)
            mmio_read(5'($urandom % 32));
        wait_reads_done();

        repeat (4) @(negedge clk);
        $display("Error counts: request %0d, hold %0d, response %0d, sequence %0d",
                 req_errs, hold_errs, rsp_errs, seq_errs);
        if (req_errs + hold_errs + rsp_errs + seq_errs == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
